// File: compile.f
+incdir+include
src/centipede_io_pkg.sv
src/io_bus_decode.sv
src/trak_select.sv
src/trak_axis_counter.sv
src/coin_led_latch.sv
src/io_read_mux.sv
src/centipede_io.sv
tb/tb_centipede_io.sv

// File: include/centipede_io_params.svh
/* widths, address block codes, axis count and synchronizer depth
   for the centipede player input and operator output block */

`ifndef CENTIPEDE_IO_PARAMS_SVH
`define CENTIPEDE_IO_PARAMS_SVH

// cpu bus
`define CIO_ADDR_W          16
`define CIO_DATA_W          8

// address block codes, compared against ab[13:10]
`define CIO_BLOCK_SW        4'd2
`define CIO_BLOCK_IN        4'd3
`define CIO_BLOCK_OUT0      4'd7
`define CIO_BLOCK_STEERCLR  4'd9

// mini-trak ball
`define CIO_TRAK_W          4
`define CIO_NUM_AXES        2
`define CIO_SYNC_STAGES     2

`endif

// File: run_sim.sh
#!/bin/sh
# build and run the centipede io testbench with verilator

verilator --binary --timing --assert -Wno-fatal -f compile.f \
   --top-module tb_centipede_io -o sim_tb > build.log 2>&1 \
   && ./obj_dir/sim_tb > sim.log 2>&1 \
   || { cat build.log; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

// File: src/centipede_io.sv
/* centipede player input and operator output block,
   bus decode, coin/led latch, trackball axes and read mux */
`timescale 1ns/1ps
`default_nettype none
`include "centipede_io_params.svh"

module centipede_io
   import centipede_io_pkg::*;
(
   input  wire                    s_6mhz,
   input  wire                    reset,
   input  wire cpu_bus_t          bus_i,
   input  wire                    vblank_i,
   input  wire [9:0]              playerinput_i,
   input  wire [7:0]              trakball_i,
   input  wire [7:0]              joystick_i,
   input  wire [7:0]              sw1_i,
   input  wire [7:0]              sw2_i,
   output wire [`CIO_DATA_W-1:0]  db_in_o,
   output wire [3:0]              led_o
);

   io_strobe_t  strobe;
   wire [2:0]   wr_addr;
   wire         wr_bit;
   coin_ctrl_t  coin_ctrl;
   trak_step_t  axis_step [`CIO_NUM_AXES];
   axis_state_t axis_state [`CIO_NUM_AXES];

   io_bus_decode u_decode (
      .s_6mhz    (s_6mhz),
      .reset     (reset),
      .bus_i     (bus_i),
      .strobe_o  (strobe),
      .wr_addr_o (wr_addr),
      .wr_bit_o  (wr_bit)
   );

   coin_led_latch u_latch (
      .s_6mhz    (s_6mhz),
      .reset     (reset),
      .wr_i      (strobe.out0_wr),
      .wr_addr_i (wr_addr),
      .wr_bit_i  (wr_bit),
      .ctrl_o    (coin_ctrl)
   );

   // flip picks which player's trackball feeds the counters
   trak_select u_trak_sel (
      .s_6mhz     (s_6mhz),
      .reset      (reset),
      .trakball_i (trakball_i),
      .flip_i     (coin_ctrl.flip),
      .axis_o     (axis_step)
   );

   for (genvar a = 0; a < `CIO_NUM_AXES; a++)
   begin : g_axis
      trak_axis_counter u_axis (
         .s_6mhz  (s_6mhz),
         .reset   (reset),
         .step_i  (axis_step[a]),
         .clear_i (strobe.steer_clr),
         .state_o (axis_state[a])
      );
   end

   // read path is purely combinational from the address
   io_read_mux u_rd_mux (
      .strobe_i      (strobe),
      .ab0_i         (bus_i.ab[0]),
      .vblank_i      (vblank_i),
      .playerinput_i (playerinput_i),
      .joystick_i    (joystick_i),
      .sw1_i         (sw1_i),
      .sw2_i         (sw2_i),
      .coin_i        (coin_ctrl),
      .axis_i        (axis_state),
      .db_in_o       (db_in_o)
   );

   assign led_o = coin_ctrl.led;

endmodule

`default_nettype wire

// File: src/centipede_io_pkg.sv
/* packed struct types for the cpu bus, decoded strobes,
   trackball steps, axis state and coin/led latch */
`default_nettype none
`include "centipede_io_params.svh"

package centipede_io_pkg;

   // cpu side of the bus as seen by the io block
   typedef struct packed {
      logic [`CIO_ADDR_W-1:0] ab;
      logic [`CIO_DATA_W-1:0] dout;
      logic                   rw_n;
      logic                   phi2;
   } cpu_bus_t;

   // read selects are levels, write strobes are one-cycle pulses
   typedef struct packed {
      logic in0_sel;
      logic in1_sel;
      logic sw_sel;
      logic out0_wr;
      logic steer_clr;
   } io_strobe_t;

   // one per trackball axis
   typedef struct packed {
      logic dir;
      logic step;
   } trak_step_t;

   typedef struct packed {
      logic                   dir;
      logic [`CIO_TRAK_W-1:0] pos;
   } axis_state_t;

   // field order matches the latch bit order 7..0
   typedef struct packed {
      logic       flip;
      logic [3:0] led;
      logic       coin_r;
      logic       coin_c;
      logic       coin_l;
   } coin_ctrl_t;

endpackage

`default_nettype wire

// File: src/coin_led_latch.sv
/* 8-bit addressable output latch for flip, player leds
   and coin counter drives */
`timescale 1ns/1ps
`default_nettype none
`include "centipede_io_params.svh"

module coin_led_latch
   import centipede_io_pkg::*;
(
   input  wire        s_6mhz,
   input  wire        reset,
   input  wire        wr_i,
   input  wire  [2:0] wr_addr_i,
   input  wire        wr_bit_i,
   output coin_ctrl_t ctrl_o
);

   logic [7:0] latch_q;

   // one bit per write, addressed by ab[2:0], data from db7
   always_ff @(posedge s_6mhz or posedge reset)
      if (reset)
      begin
         latch_q <= 8'h00;
      end
      else if (wr_i)
      begin
         latch_q[wr_addr_i] <= wr_bit_i;
      end

   // bit 7 swaps the trackball players
   assign ctrl_o.flip   = latch_q[7];
   // leds on bits 6..3
   assign ctrl_o.led    = latch_q[6:3];
   // coin counters, each drive also forces its coin input high
   assign ctrl_o.coin_r = latch_q[2];
   assign ctrl_o.coin_c = latch_q[1];
   assign ctrl_o.coin_l = latch_q[0];

endmodule

`default_nettype wire

// File: src/io_bus_decode.sv
/* io block address decode, read selects and delayed write strobes */
`timescale 1ns/1ps
`default_nettype none
`include "centipede_io_params.svh"

module io_bus_decode
   import centipede_io_pkg::*;
(
   input  wire             s_6mhz,
   input  wire             reset,
   input  wire cpu_bus_t   bus_i,
   output io_strobe_t      strobe_o,
   output logic [2:0]      wr_addr_o,
   output logic            wr_bit_o
);

   logic [3:0] block;
   logic       wr_now;
   logic       wr_q;
   logic       out0_q;
   logic       steer_q;

   // 1k blocks of the cpu map
   assign block  = bus_i.ab[13:10];
   // cpu write is phi2 high with rw_n low
   assign wr_now = bus_i.phi2 & ~bus_i.rw_n;

   // reads decode straight from the address, ab[1] splits in0/in1
   assign strobe_o.in0_sel = (block == `CIO_BLOCK_IN) & ~bus_i.ab[1];
   assign strobe_o.in1_sel = (block == `CIO_BLOCK_IN) & bus_i.ab[1];
   assign strobe_o.sw_sel  = (block == `CIO_BLOCK_SW);

   // write2 stage, strobe fires once on the first cycle of a write
   always_ff @(posedge s_6mhz or posedge reset)
      if (reset)
      begin
         wr_q    <= 1'b0;
         out0_q  <= 1'b0;
         steer_q <= 1'b0;
      end
      else
      begin
         wr_q    <= wr_now;
         out0_q  <= wr_now & ~wr_q & (block == `CIO_BLOCK_OUT0);
         steer_q <= wr_now & ~wr_q & (block == `CIO_BLOCK_STEERCLR);
      end

   // latch address and data bit 7 travel alongside the strobe
   always_ff @(posedge s_6mhz)
      if (wr_now & ~wr_q)
      begin
         wr_addr_o <= bus_i.ab[2:0];
         wr_bit_o  <= bus_i.dout[`CIO_DATA_W-1];
      end

   assign strobe_o.out0_wr   = out0_q;
   assign strobe_o.steer_clr = steer_q;

   // an unknown write qualifier would smear X into the write strobes
   a_wr_qual_known: assert property (@(posedge s_6mhz) disable iff (reset)
      !$isunknown({bus_i.phi2, bus_i.rw_n}));

endmodule

`default_nettype wire

// File: src/io_read_mux.sv
/* read words for in0, in1/joystick and option switches,
   and the read data select onto the cpu bus */
`timescale 1ns/1ps
`default_nettype none
`include "centipede_io_params.svh"

module io_read_mux
   import centipede_io_pkg::*;
(
   input  wire io_strobe_t  strobe_i,
   input  wire              ab0_i,
   input  wire              vblank_i,
   input  wire [9:0]        playerinput_i,
   input  wire [7:0]        joystick_i,
   input  wire [7:0]        sw1_i,
   input  wire [7:0]        sw2_i,
   input  wire coin_ctrl_t  coin_i,
   input  wire axis_state_t axis_i [`CIO_NUM_AXES],
   output logic [`CIO_DATA_W-1:0] db_in_o
);

   logic                  coin_r;
   logic                  coin_c;
   logic                  coin_l;
   logic [`CIO_DATA_W-1:0] in0_word;
   logic [`CIO_DATA_W-1:0] in1_word;
   logic [`CIO_DATA_W-1:0] sw_word;

   // coin counter drive pulls the coin input high
   assign coin_r = playerinput_i[9] | coin_i.coin_r;
   assign coin_c = playerinput_i[8] | coin_i.coin_c;
   assign coin_l = playerinput_i[7] | coin_i.coin_l;

   always_comb
   begin
      // ab0 picks the coin/button word over the horizontal axis
      if (ab0_i)
         in0_word = {coin_r, coin_c, coin_l, playerinput_i[4],
                     playerinput_i[1], playerinput_i[0],
                     playerinput_i[3], playerinput_i[2]};
      else
         in0_word = {axis_i[0].dir, vblank_i, playerinput_i[6],
                     playerinput_i[5], axis_i[0].pos};

      // joystick or vertical axis
      if (ab0_i)
         in1_word = joystick_i;
      else
         in1_word = {axis_i[1].dir, 3'b000, axis_i[1].pos};

      // option switch banks
      sw_word = ab0_i ? sw2_i : sw1_i;
   end

   // selects are exclusive, anything else reads as zero
   always_comb
   begin
      if (strobe_i.in0_sel)
         db_in_o = in0_word;
      else if (strobe_i.in1_sel)
         db_in_o = in1_word;
      else if (strobe_i.sw_sel)
         db_in_o = sw_word;
      else
         db_in_o = '0;
   end

endmodule

`default_nettype wire

// File: src/trak_axis_counter.sv
/* one trackball axis, direction latch and up/down position counter */
`timescale 1ns/1ps
`default_nettype none
`include "centipede_io_params.svh"

module trak_axis_counter
   import centipede_io_pkg::*;
(
   input  wire         s_6mhz,
   input  wire         reset,
   input  wire trak_step_t step_i,
   input  wire         clear_i,
   output axis_state_t state_o
);

   always_ff @(posedge s_6mhz or posedge reset)
      if (reset)
      begin
         state_o <= '0;
      end
      else
      begin
         // dir latches on every step, a clear leaves it alone
         if (step_i.step)
            state_o.dir <= step_i.dir;

         // steer clear wins over a step in the same cycle
         if (clear_i)
            state_o.pos <= '0;
         else if (step_i.step)
         begin
            // count follows the new dir, wraps mod 16
            if (step_i.dir)
               state_o.pos <= state_o.pos + `CIO_TRAK_W'(1);
            else
               state_o.pos <= state_o.pos - `CIO_TRAK_W'(1);
         end
      end

   // one trackball edge must arrive as a single-cycle step, else it counts twice
   a_step_pulse: assert property (@(posedge s_6mhz) disable iff (reset)
      step_i.step |=> !step_i.step);

endmodule

`default_nettype wire

// File: src/trak_select.sv
/* trackball line select by flip, synchronizer into s_6mhz
   and step pulse generation for each axis */
`timescale 1ns/1ps
`default_nettype none
`include "centipede_io_params.svh"

module trak_select
   import centipede_io_pkg::*;
(
   input  wire        s_6mhz,
   input  wire        reset,
   input  wire  [7:0] trakball_i,
   input  wire        flip_i,
   output trak_step_t axis_o [`CIO_NUM_AXES]
);

   // axis 0 is horizontal on bits 7..4, axis 1 vertical on bits 3..0
   // odd bits belong to player 1, even bits to player 2
   for (genvar a = 0; a < `CIO_NUM_AXES; a++)
   begin : g_axis
      localparam int BASE = 4 * (`CIO_NUM_AXES - 1 - a);

      logic [1:0]                        raw;
      logic [`CIO_SYNC_STAGES-1:0][1:0] sync_q;
      logic                              ck_d;

      // {dir, ck} of the player picked by flip
      assign raw = flip_i ? {trakball_i[BASE+3], trakball_i[BASE+1]}
                          : {trakball_i[BASE+2], trakball_i[BASE]};

      always_ff @(posedge s_6mhz or posedge reset)
         if (reset)
         begin
            sync_q    <= '0;
            ck_d      <= 1'b0;
            axis_o[a] <= '0;
         end
         else
         begin
            sync_q[0] <= raw;
            for (int s = 1; s < `CIO_SYNC_STAGES; s++)
               sync_q[s] <= sync_q[s-1];
            // previous synced clock level for edge detect
            ck_d <= sync_q[`CIO_SYNC_STAGES-1][0];
            axis_o[a].dir  <= sync_q[`CIO_SYNC_STAGES-1][1];
            // rising edge of the trackball clock
            axis_o[a].step <= sync_q[`CIO_SYNC_STAGES-1][0] & ~ck_d;
         end
   end

endmodule

`default_nettype wire

// File: tb/tb_centipede_io.sv
/* testbench for the centipede io block, random bus reads, latch writes,
   trackball pulse trains and steer clear against a reference model */
`timescale 1ns/1ps
`default_nettype none
`include "centipede_io_params.svh"

module tb_centipede_io
   import centipede_io_pkg::*;
();

   logic        s_6mhz;
   logic        reset;
   cpu_bus_t    bus;
   logic        vblank;
   logic [9:0]  pin;
   logic [7:0]  trak;
   logic [7:0]  joy;
   logic [7:0]  sw1;
   logic [7:0]  sw2;
   wire  [7:0]  db_in;
   wire  [3:0]  led;

   // reference model state
   logic [7:0]  m_latch;
   logic [1:0]  m_dir;
   logic [3:0]  m_pos [2];
   int          errors;
   int          checks;
   int unsigned seed_v;

   centipede_io UUT (
      .s_6mhz        (s_6mhz),
      .reset         (reset),
      .bus_i         (bus),
      .vblank_i      (vblank),
      .playerinput_i (pin),
      .trakball_i    (trak),
      .joystick_i    (joy),
      .sw1_i         (sw1),
      .sw2_i         (sw2),
      .db_in_o       (db_in),
      .led_o         (led)
   );

   always #4 s_6mhz = ~s_6mhz;

   // expected read words from the mux rules
   function automatic logic [7:0] exp_in0(input logic ab0);
      if (ab0)
         return {pin[9] | m_latch[2], pin[8] | m_latch[1], pin[7] | m_latch[0],
                 pin[4], pin[1], pin[0], pin[3], pin[2]};
      return {m_dir[0], vblank, pin[6], pin[5], m_pos[0]};
   endfunction

   function automatic logic [7:0] exp_in1(input logic ab0);
      if (ab0)
         return joy;
      return {m_dir[1], 3'b000, m_pos[1]};
   endfunction

   task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   // stimulus changes 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge s_6mhz);
      #1;
   endtask

   task automatic hold(input int n);
      for (int i = 0; i < n; i++)
         next_cycle();
   endtask

   task automatic bus_idle();
      bus.phi2 = 1'b0;
      bus.rw_n = 1'b1;
   endtask

   task automatic random_inputs();
      vblank = 1'($urandom);
      pin    = 10'($urandom);
      joy    = 8'($urandom);
      sw1    = 8'($urandom);
      sw2    = 8'($urandom);
   endtask

   // read data is sampled mid-cycle, well clear of both edges
   task automatic read_word(input logic [3:0] blk, input logic ab1, input logic ab0,
                            output logic [7:0] d);
      bus.ab   = {2'($urandom), blk, 8'($urandom), ab1, ab0};
      bus.rw_n = 1'b1;
      bus.phi2 = 1'b1;
      @(negedge s_6mhz);
      d = db_in;
      next_cycle();
      bus_idle();
   endtask

   // one write cycle, returns after the edge that applies the strobe
   task automatic write_io(input logic [3:0] blk, input logic [2:0] addr, input logic bit_v);
      bus.ab   = {2'($urandom), blk, 7'($urandom), addr};
      bus.dout = {bit_v, 7'($urandom)};
      bus.rw_n = 1'b0;
      bus.phi2 = 1'b1;
      next_cycle();
      bus_idle();
      next_cycle();
   endtask

   task automatic check_axes();
      logic [7:0] d;
      read_word(`CIO_BLOCK_IN, 1'b0, 1'b0, d);
      check("in0 axis0", d, exp_in0(1'b0));
      read_word(`CIO_BLOCK_IN, 1'b1, 1'b0, d);
      check("in1 axis1", d, exp_in1(1'b0));
   endtask

   task automatic latch_write(input logic [2:0] addr, input logic bit_v);
      logic [7:0] d;
      write_io(`CIO_BLOCK_OUT0, addr, bit_v);
      m_latch[addr] = bit_v;
      check("led_o", {4'h0, led}, {4'h0, m_latch[6:3]});
      random_inputs();
      read_word(`CIO_BLOCK_IN, 1'b0, 1'b1, d);
      check("in0 coin word", d, exp_in0(1'b1));
   endtask

   task automatic steer_clear();
      write_io(`CIO_BLOCK_STEERCLR, 3'($urandom), 1'($urandom));
      m_pos[0] = 4'h0;
      m_pos[1] = 4'h0;
      check_axes();
   endtask

   // sel_odd picks player 1 lines (odd bits) or player 2 lines (even bits)
   task automatic pulse_train(input logic sel_odd, input int n);
      logic [1:0] en;
      logic [1:0] dr;
      logic [7:0] lv;
      int         base;
      for (int i = 0; i < n; i++)
      begin
         en = 2'($urandom);
         dr = 2'($urandom);
         lv = 8'h00;
         // direction first with the clock low, then the rising clock
         for (int a = 0; a < 2; a++)
         begin
            base = (a == 0) ? 4 : 0;
            lv[base + 2 + int'(sel_odd)] = dr[a];
         end
         trak = lv;
         hold(8);
         for (int a = 0; a < 2; a++)
         begin
            base = (a == 0) ? 4 : 0;
            lv[base + int'(sel_odd)] = en[a];
         end
         trak = lv;
         hold(8);
         if (sel_odd == m_latch[7])
            for (int a = 0; a < 2; a++)
               if (en[a])
               begin
                  m_dir[a] = dr[a];
                  m_pos[a] = dr[a] ? m_pos[a] + 4'd1 : m_pos[a] - 4'd1;
               end
         check_axes();
      end
      trak = 8'h00;
      hold(8);
   endtask

   initial
   begin
      logic [7:0] d;
      logic [3:0] blk;
      logic       ab0;
      seed_v   = $urandom(32'hc460_e0a8);
      s_6mhz   = 1'b0;
      reset    = 1'b1;
      bus      = '0;
      bus.rw_n = 1'b1;
      vblank   = 1'b0;
      pin      = 10'h000;
      trak     = 8'h00;
      joy      = 8'h00;
      sw1      = 8'h00;
      sw2      = 8'h00;
      m_latch  = 8'h00;
      m_dir    = 2'b00;
      m_pos[0] = 4'h0;
      m_pos[1] = 4'h0;
      errors   = 0;
      checks   = 0;
      repeat (3) @(posedge s_6mhz);
      #1;
      reset = 1'b0;

      // state right after reset
      check("led_o", {4'h0, led}, 8'h00);
      read_word(`CIO_BLOCK_IN, 1'b0, 1'b0, d);
      check("in0 dir/pos", {3'b000, d[7], d[3:0]}, 8'h00);
      read_word(`CIO_BLOCK_IN, 1'b1, 1'b0, d);
      check("in1 dir/pos", {3'b000, d[7], d[3:0]}, 8'h00);

      // random combinational reads
      for (int i = 0; i < 40; i++)
      begin
         random_inputs();
         ab0 = 1'($urandom);
         case (2'($urandom))
            2'd0:
            begin
               read_word(`CIO_BLOCK_SW, 1'($urandom), ab0, d);
               check("sw word", d, ab0 ? sw2 : sw1);
            end
            2'd1:
            begin
               read_word(`CIO_BLOCK_IN, 1'b1, 1'b1, d);
               check("in1 joystick", d, exp_in1(1'b1));
            end
            2'd2:
            begin
               read_word(`CIO_BLOCK_IN, 1'b0, 1'b1, d);
               check("in0 coin word", d, exp_in0(1'b1));
            end
            default:
            begin
               blk = 4'($urandom);
               if (blk == `CIO_BLOCK_SW || blk == `CIO_BLOCK_IN)
                  blk = 4'd12;
               read_word(blk, 1'($urandom), ab0, d);
               check("unselected read", d, 8'h00);
            end
         endcase
      end

      // latch writes to leds and coin drives, flip stays clear
      for (int i = 0; i < 24; i++)
         latch_write(3'($urandom % 7), 1'($urandom));

      // trackball counting with player 2 lines active
      pulse_train(1'b0, 24);

      // flip hands the counters to the player 1 lines
      latch_write(3'd7, 1'b1);
      pulse_train(1'b0, 8);
      pulse_train(1'b1, 16);
      latch_write(3'd7, 1'b0);

      // steer clear zeroes pos but keeps dir
      steer_clear();
      pulse_train(1'b0, 6);
      steer_clear();

      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
